// ==== Bender.yml ====
package:
  name: vidc_clk_ctrl

sources:
  - target: any(rtl, sim)
    files:
      - rtl/vidc_clk_pkg.sv
      - rtl/clk_enable_gen.sv
      - rtl/pll_profile_rom.sv
      - rtl/reconfig_sequencer.sv
      - rtl/scan_serializer.sv
      - rtl/vidc_clk_ctrl.sv

  - target: sim
    files:
      - sim/vidc_clk_ctrl_props.sv
      - sim/tb_vidc_clk_ctrl.sv

// ==== build.f ====
rtl/vidc_clk_pkg.sv
rtl/clk_enable_gen.sv
rtl/pll_profile_rom.sv
rtl/reconfig_sequencer.sv
rtl/scan_serializer.sv
rtl/vidc_clk_ctrl.sv
sim/vidc_clk_ctrl_props.sv
sim/tb_vidc_clk_ctrl.sv

// ==== rtl/clk_enable_gen.sv ====
`timescale 1ns/1ps

module clk_enable_gen (
	input  logic clk_sys,
	input  logic rst_i,
	output logic clk2m_en_o,
	output logic clk8m_en_o
);
	import vidc_clk_pkg::*;

	logic [CLKEN_CNT_W-1:0] clken_cnt; // runs 0 .. CLKEN_DIV-1

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			clken_cnt  <= '0;
			clk2m_en_o <= 1'b0;
			clk8m_en_o <= 1'b0;
		end else begin
			if (clken_cnt == CLKEN_CNT_W'(CLKEN_DIV - 1))
				clken_cnt <= '0;
			else
				clken_cnt <= clken_cnt + 1'b1;

			// both strobes fire together at count 0
			clk2m_en_o <= (clken_cnt == '0);
			clk8m_en_o <= ((clken_cnt % CLK8M_PHASE) == 0); // four phases per cycle
		end
	end

endmodule

// ==== rtl/pll_profile_rom.sv ====
`timescale 1ns/1ps

module pll_profile_rom #(
	parameter int PROFILE = 0
) (
	input  logic                                 clk_sys,
	input  logic                                 rden_i,
	input  logic [vidc_clk_pkg::SCAN_ADDR_W-1:0] addr_i,
	output logic                                 q_o
);
	import vidc_clk_pkg::*;

	logic [SCAN_BITS-1:0] image;

	assign image = PROFILE_BITS[PROFILE];

	// registered read, q holds while rden is low
	always_ff @(posedge clk_sys) begin
		if (rden_i)
			q_o <= image[addr_i];
	end

endmodule

// ==== rtl/reconfig_sequencer.sv ====
`timescale 1ns/1ps

module reconfig_sequencer (
	input  logic                                 clk_sys,
	input  logic                                 rst_i,
	input  logic [vidc_clk_pkg::SEL_W-1:0]       vidbaseclk_i,
	input  logic                                 scandone_i,
	output logic                                 vid_clk_ena_o,
	output logic                                 rom_rden_o,
	output logic [vidc_clk_pkg::SCAN_ADDR_W-1:0] rom_addr_o,
	output logic [1:0]                           profile_o,
	output logic                                 configupdate_o,
	output logic                                 pll_areset_o
);
	import vidc_clk_pkg::*;

	logic [STATE_W-1:0] state;
	logic [SEL_W-1:0]   sel_q;  // last select seen in idle
	logic [WDOG_W-1:0]  wdog;

	// 01 -> 25 MHz, 10 -> 36 MHz, anything else -> 24 MHz
	function automatic logic [1:0] sel_to_profile(input logic [SEL_W-1:0] sel);
		case (sel)
			2'b01:   return 2'(PROFILE_25);
			2'b10:   return 2'(PROFILE_36);
			default: return 2'(PROFILE_24);
		endcase
	endfunction

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			state          <= ST_IDLE;
			sel_q          <= SEL_RESET;
			profile_o      <= sel_to_profile(SEL_RESET);
			vid_clk_ena_o  <= 1'b1;
			rom_rden_o     <= 1'b0;
			rom_addr_o     <= '0;
			configupdate_o <= 1'b0;
			wdog           <= '0;
		end else begin
			configupdate_o <= 1'b0; // single cycle pulse

			case (state)
				ST_IDLE: begin
					vid_clk_ena_o <= 1'b1;
					if (vidbaseclk_i != sel_q) begin
						// new base clock, stop the pixel clock and start streaming
						sel_q         <= vidbaseclk_i;
						profile_o     <= sel_to_profile(vidbaseclk_i);
						vid_clk_ena_o <= 1'b0;
						rom_addr_o    <= '0;
						rom_rden_o    <= 1'b1;
						state         <= ST_SHIFT;
					end
				end

				ST_SHIFT: begin
					rom_addr_o <= rom_addr_o + 1'b1;
					if (rom_addr_o == SCAN_ADDR_W'(SCAN_BITS - 1)) begin
						rom_rden_o <= 1'b0;
						state      <= ST_DRAIN;
					end
				end

				// rom and serializer still hold two bits in flight,
				// the address keeps counting to time them out
				ST_DRAIN: begin
					rom_addr_o <= rom_addr_o + 1'b1;
					if (rom_addr_o == SCAN_ADDR_W'(SCAN_BITS + 1)) begin
						configupdate_o <= 1'b1;
						wdog           <= WDOG_W'(RECONFIG_TIMEOUT);
						state          <= ST_UPDATE;
					end
				end

				ST_UPDATE: begin
					wdog  <= wdog - 1'b1;
					state <= ST_WAIT;
				end

				ST_WAIT: begin
					wdog <= wdog - 1'b1;
					if (scandone_i || wdog == WDOG_W'(1))
						state <= ST_IDLE; // vid clock back on from idle
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// pll never signalled scandone, kick it
	assign pll_areset_o = (state == ST_WAIT) && (wdog == WDOG_W'(1));

endmodule

// ==== rtl/scan_serializer.sv ====
`timescale 1ns/1ps

module scan_serializer (
	input  logic                                   clk_sys,
	input  logic                                   rst_i,
	input  logic [vidc_clk_pkg::PROFILE_COUNT-1:0] rom_q_i,
	input  logic [1:0]                             profile_i,
	input  logic                                   rom_rden_i,
	output logic                                   scandata_o,
	output logic                                   scanclkena_o
);

	logic rden_q; // lines up with rom output

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			rden_q       <= 1'b0;
			scanclkena_o <= 1'b0;
		end else begin
			rden_q       <= rom_rden_i;
			scanclkena_o <= rden_q;
		end
	end

	// data follows the enable
	always_ff @(posedge clk_sys) begin
		scandata_o <= rom_q_i[profile_i];
	end

endmodule

// ==== rtl/vidc_clk_ctrl.sv ====
`timescale 1ns/1ps

module vidc_clk_ctrl (
	input  logic                           clk_sys,
	input  logic                           rst_i,
	input  logic [vidc_clk_pkg::SEL_W-1:0] vidbaseclk_i,
	input  logic                           scandone_i,
	output logic                           clk2m_en_o,
	output logic                           clk8m_en_o,
	output logic                           vid_clk_ena_o,
	output logic                           scandata_o,
	output logic                           scanclkena_o,
	output logic                           configupdate_o,
	output logic                           pll_areset_o
);
	import vidc_clk_pkg::*;

	logic [SCAN_ADDR_W-1:0]   rom_addr;
	logic                     rom_rden;
	logic [PROFILE_COUNT-1:0] rom_q;    // one bit per stored profile
	logic [1:0]               profile;

	clk_enable_gen u_clken (
		.clk_sys    (clk_sys),
		.rst_i      (rst_i),
		.clk2m_en_o (clk2m_en_o),
		.clk8m_en_o (clk8m_en_o)
	);

	reconfig_sequencer u_seq (
		.clk_sys        (clk_sys),
		.rst_i          (rst_i),
		.vidbaseclk_i   (vidbaseclk_i),
		.scandone_i     (scandone_i),
		.vid_clk_ena_o  (vid_clk_ena_o),
		.rom_rden_o     (rom_rden),
		.rom_addr_o     (rom_addr),
		.profile_o      (profile),
		.configupdate_o (configupdate_o),
		.pll_areset_o   (pll_areset_o)
	);

	// all roms read in parallel, the serializer picks one
	for (genvar p = 0; p < PROFILE_COUNT; p++) begin : g_rom
		pll_profile_rom #(
			.PROFILE (p)
		) u_rom (
			.clk_sys (clk_sys),
			.rden_i  (rom_rden),
			.addr_i  (rom_addr),
			.q_o     (rom_q[p])
		);
	end

	scan_serializer u_ser (
		.clk_sys      (clk_sys),
		.rst_i        (rst_i),
		.rom_q_i      (rom_q),
		.profile_i    (profile),
		.rom_rden_i   (rom_rden),
		.scandata_o   (scandata_o),
		.scanclkena_o (scanclkena_o)
	);

endmodule

// ==== rtl/vidc_clk_pkg.sv ====
package vidc_clk_pkg;

	// clock enable divider, clk_sys is 40 MHz
	localparam int CLKEN_DIV   = 20;
	localparam int CLKEN_CNT_W = $clog2(CLKEN_DIV);
	localparam int CLK8M_PHASE = 5; // 8 MHz strobes at counts 0, 5, 10, 15

	// pll scan chain
	localparam int SCAN_BITS   = 144;
	localparam int SCAN_ADDR_W = 8;

	// stored profiles, one rom each
	localparam int PROFILE_COUNT = 3;
	localparam int PROFILE_24    = 0;
	localparam int PROFILE_25    = 1;
	localparam int PROFILE_36    = 2;

	// base clock select from the core
	localparam int                SEL_W     = 2;
	localparam logic [SEL_W-1:0] SEL_RESET = 2'b10;

	// watchdog after configupdate
	localparam int WDOG_W           = 10;
	localparam int RECONFIG_TIMEOUT = 1000;

	// sequencer states
	localparam int                  STATE_W   = 3;
	localparam logic [STATE_W-1:0] ST_IDLE   = 3'd0;
	localparam logic [STATE_W-1:0] ST_SHIFT  = 3'd1;
	localparam logic [STATE_W-1:0] ST_DRAIN  = 3'd2;
	localparam logic [STATE_W-1:0] ST_UPDATE = 3'd3;
	localparam logic [STATE_W-1:0] ST_WAIT   = 3'd4;

	// scan chain images, bit n goes out at rom address n
	localparam logic [SCAN_BITS-1:0] PROFILE_BITS [PROFILE_COUNT] = '{
		144'h0201_8030_0c04_0060_1c08_00c0_3010_0180_6020, // 24 MHz family
		144'h0241_8030_0a04_0050_1c08_00c0_2810_0140_6024, // 25 MHz family
		144'h0381_c038_0e04_0070_1e08_00e0_3810_01c0_7038  // 36 MHz family
	};

endpackage

// ==== sim/tb_vidc_clk_ctrl.sv ====
`timescale 1ns/1ps

module tb_vidc_clk_ctrl;
	import vidc_clk_pkg::*;

	localparam int CYCLE_LIMIT = 6000; // four reconfigs plus one watchdog run plus margin
	localparam int WAIT_LIMIT  = 400;  // stream plus drain

	logic             clk_sys;
	logic             rst_i;
	logic [SEL_W-1:0] vidbaseclk_i;
	logic             scandone_i;
	logic             clk2m_en_o;
	logic             clk8m_en_o;
	logic             vid_clk_ena_o;
	logic             scandata_o;
	logic             scanclkena_o;
	logic             configupdate_o;
	logic             pll_areset_o;

	int          cyc = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	logic [31:0] lfsr_state;
	bit          scan_q [$]; // bits taken by the scan chain
	int          last_scan_cyc;
	int          cfg_cyc;
	int          cfg_cnt = 0;
	int          areset_cyc;
	int          areset_cnt = 0;
	int          vid_on_in_scan = 0;

	vidc_clk_ctrl UUT (
		.clk_sys        (clk_sys),
		.rst_i          (rst_i),
		.vidbaseclk_i   (vidbaseclk_i),
		.scandone_i     (scandone_i),
		.clk2m_en_o     (clk2m_en_o),
		.clk8m_en_o     (clk8m_en_o),
		.vid_clk_ena_o  (vid_clk_ena_o),
		.scandata_o     (scandata_o),
		.scanclkena_o   (scanclkena_o),
		.configupdate_o (configupdate_o),
		.pll_areset_o   (pll_areset_o)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cyc = cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			$display("ERROR: run stopped after %0d cycles, a test never finished", cyc);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_equal(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		assert (ok) else begin
			$display("ERROR at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	// taps 32 22 2 1 with one step per bit
	function automatic int draw_bits(input int n);
		logic fb;
		int   val;
		val = 0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val        = (val << 1) | fb;
		end
		return val;
	endfunction

	// sampled mid cycle where outputs are settled
	task automatic collect_scan();
		forever begin
			@(negedge clk_sys);
			if (scanclkena_o === 1'b1) begin
				scan_q.push_back(scandata_o);
				last_scan_cyc = cyc;
				if (vid_clk_ena_o !== 1'b0)
					vid_on_in_scan++;
			end
			if (configupdate_o === 1'b1) begin
				cfg_cyc = cyc;
				cfg_cnt++;
			end
			if (pll_areset_o === 1'b1) begin
				areset_cyc = cyc;
				areset_cnt++;
			end
		end
	endtask

	task automatic check_stream(input int prof);
		logic [SCAN_BITS-1:0] got;
		got = '0;
		check_equal("scan bit count", scan_q.size(), SCAN_BITS);
		for (int i = 0; i < scan_q.size() && i < SCAN_BITS; i++)
			got[i] = scan_q[i];
		assert (got == PROFILE_BITS[prof]) else begin
			$display("MISMATCH at %0t ns: scandata_o stream is %h, expected %h",
				$time, got, PROFILE_BITS[prof]);
			errors++;
		end
		check_equal("configupdate_o delay after last scan bit", cfg_cyc - last_scan_cyc, 1);
		check_equal("scan cycles with vid_clk_ena_o high", vid_on_in_scan, 0);
	endtask

	task automatic wait_cfg(input int base);
		int n;
		n = 0;
		while (cfg_cnt == base && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		check_true(cfg_cnt != base, "configupdate_o never pulsed after a select change");
	endtask

	task automatic wait_vid_on(input int limit);
		int n;
		n = 0;
		while (vid_clk_ena_o !== 1'b1 && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		check_true(vid_clk_ena_o === 1'b1, "vid_clk_ena_o did not come back high");
	endtask

	task automatic give_scandone(input int delay);
		repeat (delay) @(negedge clk_sys);
		scandone_i = 1'b1;
		wait_vid_on(10);
		scandone_i = 1'b0;
	endtask

	task automatic start_reconfig(input logic [SEL_W-1:0] sel);
		scan_q.delete();
		vid_on_in_scan = 0;
		vidbaseclk_i   = sel;
	endtask

	task automatic finish_test(input string name, input int err0);
		tests_run++;
		if (errors != err0)
			tests_failed++;
		$display("test %s: %0d errors", name, errors - err0);
	endtask

	task automatic test_clock_enables();
		int err0, last2, last8, n2;
		err0  = errors;
		last2 = -1;
		last8 = -1;
		n2    = 0;
		for (int i = 0; i < 4 * CLKEN_DIV; i++) begin
			@(negedge clk_sys);
			if (clk8m_en_o) begin
				if (last8 >= 0)
					check_equal("clk8m_en_o period", cyc - last8, CLK8M_PHASE);
				last8 = cyc;
			end
			if (clk2m_en_o) begin
				check_equal("clk8m_en_o at clk2m_en_o", clk8m_en_o, 1);
				if (last2 >= 0)
					check_equal("clk2m_en_o period", cyc - last2, CLKEN_DIV);
				last2 = cyc;
				n2++;
			end
		end
		check_true(n2 >= 3, "clk2m_en_o pulsed too rarely");
		finish_test("clock enables", err0);
	endtask

	task automatic test_reset_reconfig();
		int err0;
		err0 = errors;
		wait_cfg(0); // select 00 differs from the reset value
		check_stream(PROFILE_24);
		give_scandone(0);
		finish_test("reconfig after reset", err0);
	endtask

	task automatic test_change_25();
		int err0, base, rst_base, delay;
		err0     = errors;
		base     = cfg_cnt;
		rst_base = areset_cnt;
		start_reconfig(2'b01);
		wait_cfg(base);
		check_stream(PROFILE_25);
		delay = draw_bits(5);
		give_scandone(delay);
		check_equal("pll_areset_o pulses", areset_cnt - rst_base, 0);
		finish_test("change to 25 MHz", err0);
	endtask

	task automatic test_watchdog();
		int err0, base, rst_base, n;
		err0     = errors;
		base     = cfg_cnt;
		rst_base = areset_cnt;
		n        = 0;
		start_reconfig(2'b10);
		wait_cfg(base);
		check_stream(PROFILE_36);
		while (areset_cnt == rst_base && n < RECONFIG_TIMEOUT + 20) begin
			@(negedge clk_sys);
			n++;
		end
		check_true(areset_cnt != rst_base, "pll_areset_o never pulsed without scandone");
		check_equal("pll_areset_o delay after configupdate_o", areset_cyc - cfg_cyc,
			RECONFIG_TIMEOUT - 1);
		wait_vid_on(10);
		finish_test("watchdog", err0);
	endtask

	task automatic test_steady();
		int err0, bad;
		err0 = errors;
		bad  = 0;
		repeat (300) begin
			@(negedge clk_sys);
			if (scanclkena_o !== 1'b0 || configupdate_o !== 1'b0 || pll_areset_o !== 1'b0
				|| vid_clk_ena_o !== 1'b1)
				bad++;
		end
		check_true(bad == 0, "scan activity or a pll pulse while the select was steady");
		finish_test("steady select", err0);
	endtask

	initial collect_scan();

	initial begin
		clk_sys      = 1'b0;
		rst_i        = 1'b1;
		vidbaseclk_i = 2'b00;
		scandone_i   = 1'b0;
		lfsr_state   = 32'haa1a_207b;
		repeat (10) @(negedge clk_sys);
		rst_i = 1'b0;

		test_clock_enables();
		test_reset_reconfig();
		test_change_25();
		test_watchdog();
		test_steady();

		$display("tests run %0d, tests failed %0d, failed checks %0d, failed assertions %0d",
			tests_run, tests_failed, errors, UUT.u_props.fail_cnt);
		if (errors == 0 && UUT.u_props.fail_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== sim/vidc_clk_ctrl_props.sv ====
`timescale 1ns/1ps

module vidc_clk_ctrl_props (
	input logic clk_sys,
	input logic rst_i,
	input logic vid_clk_ena_i,
	input logic scanclkena_i,
	input logic configupdate_i,
	input logic pll_areset_i
);

	int fail_cnt = 0; // assertion failures seen so far

	// pulses toward the pll last one cycle
	a_cfg_pulse: assert property (@(posedge clk_sys) disable iff (rst_i)
		configupdate_i |=> !configupdate_i)
		else begin
			$error("configupdate_o stayed high for more than one cycle");
			fail_cnt++;
		end

	a_areset_pulse: assert property (@(posedge clk_sys) disable iff (rst_i)
		pll_areset_i |=> !pll_areset_i)
		else begin
			$error("pll_areset_o stayed high for more than one cycle");
			fail_cnt++;
		end

	a_gated_scan: assert property (@(posedge clk_sys) disable iff (rst_i)
		!(scanclkena_i && vid_clk_ena_i))
		else begin
			$error("scan chain shifting while the pixel clock is enabled");
			fail_cnt++;
		end

	a_cfg_after_scan: assert property (@(posedge clk_sys) disable iff (rst_i)
		!(configupdate_i && scanclkena_i))
		else begin
			$error("configupdate_o raised while the scan chain is still shifting");
			fail_cnt++;
		end

endmodule

bind vidc_clk_ctrl vidc_clk_ctrl_props u_props (
	.clk_sys        (clk_sys),
	.rst_i          (rst_i),
	.vid_clk_ena_i  (vid_clk_ena_o),
	.scanclkena_i   (scanclkena_o),
	.configupdate_i (configupdate_o),
	.pll_areset_i   (pll_areset_o)
);
